// File: common/dcache_pkg.sv
package dcache_pkg;

   // data word on both the processor side and the memory side
   typedef logic [31:0] word_t;

   // byte address
   typedef logic [31:0] addr_t;

   // byte-in-block bits of the address
   // bit 2 picks the word, bits 1:0 are the byte in the word
   localparam int WORD_OFFSET_BITS = 3;

   // log2 of the number of sets, eight sets by default
   localparam int DEFAULT_INDEX_BITS = 3;

   // way number, 0 is the left way and 1 is the right way
   typedef logic [0:0] way_t;

   // controller states
   // WB1/WB2 write back a dirty victim, READ1/READ2 fill the block
   // DIRTY looks at one frame of the flush walk, FLUSH1/FLUSH2 write it back
   typedef enum logic [3:0] {
      IDLE,
      WB1,
      WB2,
      READ1,
      READ2,
      DIRTY,
      FLUSH1,
      FLUSH2,
      HALT
   } cache_state_t;

endpackage

// File: logic/flush_counter.sv
`timescale 1ns/1ps

module flush_counter
   import dcache_pkg::*;
#(
   parameter int INDEX_BITS = DEFAULT_INDEX_BITS
)
(
   input  logic                  CLK,
   input  logic                  nRST,
   input  logic                  count_en,
   input  logic                  count_clr,
   output way_t                  frame_way,
   output logic [INDEX_BITS-1:0] frame_index,
   output logic                  walk_done
);

   // top bit flags the end of the walk, next bit is the way, the rest the set
   logic [INDEX_BITS+1:0] count;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         count <= '0;
      end
      else if (count_clr)
      begin
         count <= '0;
      end
      else if (count_en && !walk_done)
      begin
         count <= count + 1'b1;
      end
   end

   // all sets of way 0 are visited before way 1
   assign frame_index = count[INDEX_BITS-1:0];
   assign frame_way   = count[INDEX_BITS];
   assign walk_done   = count[INDEX_BITS+1];

endmodule

// File: dcache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
   import dcache_pkg::*;
(
   input  logic         CLK,
   input  logic         nRST,
   input  logic         halt,
   input  logic         dmemREN,
   input  logic         dmemWEN,
   input  logic         dwait,
   input  logic         hit,
   input  logic         victim_dirty,
   input  logic         frame_dirty,
   input  logic         walk_done,
   output cache_state_t state,
   output logic         count_en,
   output logic         count_clr,
   output logic         dREN,
   output logic         dWEN,
   output logic         flushed
);

   cache_state_t next_state;
   logic         req;

   // any processor access this cycle
   assign req = dmemREN | dmemWEN;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= next_state;
      end
   end

   always_comb
   begin
      next_state = state;
      count_en   = 1'b0;
      count_clr  = 1'b0;

      unique case (state)
         IDLE:
         begin
            // halt wins over a pending access
            if (halt)
            begin
               count_clr  = 1'b1;
               next_state = DIRTY;
            end
            else if (req && !hit)
            begin
               // dirty victim goes out to memory before the fill
               if (victim_dirty)
               begin
                  next_state = WB1;
               end
               else
               begin
                  next_state = READ1;
               end
            end
         end
         WB1:
         begin
            if (!dwait)
            begin
               next_state = WB2;
            end
         end
         WB2:
         begin
            if (!dwait)
            begin
               next_state = READ1;
            end
         end
         READ1:
         begin
            if (!dwait)
            begin
               next_state = READ2;
            end
         end
         READ2:
         begin
            // block valid next cycle, hit is then seen in IDLE
            if (!dwait)
            begin
               next_state = IDLE;
            end
         end
         DIRTY:
         begin
            if (walk_done)
            begin
               next_state = HALT;
            end
            else if (frame_dirty)
            begin
               next_state = FLUSH1;
            end
            else
            begin
               // clean or invalid frame, skip it
               count_en = 1'b1;
            end
         end
         FLUSH1:
         begin
            if (!dwait)
            begin
               next_state = FLUSH2;
            end
         end
         FLUSH2:
         begin
            // frame written back, move on to the next one
            if (!dwait)
            begin
               count_en   = 1'b1;
               next_state = DIRTY;
            end
         end
         HALT:
         begin
            // only reset leaves here
            next_state = HALT;
         end
         default:
         begin
            next_state = IDLE;
         end
      endcase
   end

   // memory strobes held for the whole state, so they stay up while dwait is high
   assign dWEN = (state == WB1) || (state == WB2) ||
                 (state == FLUSH1) || (state == FLUSH2);
   assign dREN = (state == READ1) || (state == READ2);

   assign flushed = (state == HALT);

endmodule

// File: dcache/block_store.sv
`timescale 1ns/1ps

module block_store
   import dcache_pkg::*;
#(
   parameter int INDEX_BITS = DEFAULT_INDEX_BITS
)
(
   input  logic                  CLK,
   input  logic                  nRST,
   input  cache_state_t          state,
   input  logic                  dmemREN,
   input  logic                  dmemWEN,
   input  logic                  dwait,
   input  addr_t                 dmemaddr,
   input  word_t                 dmemstore,
   input  word_t                 dload,
   input  way_t                  frame_way,
   input  logic [INDEX_BITS-1:0] frame_index,
   output logic                  hit,
   output logic                  victim_dirty,
   output logic                  frame_dirty,
   output logic                  dhit,
   output word_t                 dmemload,
   output word_t                 dstore,
   output addr_t                 daddr
);

   localparam int SETS     = 1 << INDEX_BITS;
   localparam int TAG_BITS = 32 - INDEX_BITS - WORD_OFFSET_BITS;

   typedef logic [TAG_BITS-1:0]   tag_t;
   typedef logic [INDEX_BITS-1:0] index_t;

   // storage, indexed [way][set]
   tag_t  tags  [2][SETS];
   word_t data0 [2][SETS];
   word_t data1 [2][SETS];
   logic  valid [2][SETS];
   logic  dirty [2][SETS];
   // per set, the least recently used way, which is also the next victim
   way_t  lru   [SETS];

   tag_t   req_tag;
   index_t req_index;
   logic   req_word;
   logic   hit_left;
   logic   hit_right;
   way_t   hit_way;
   way_t   victim;
   logic   rd_hit;
   logic   wr_hit;
   logic   xfer;
   logic   second;

   // split the processor address
   assign req_tag   = dmemaddr[31 -: TAG_BITS];
   assign req_index = dmemaddr[WORD_OFFSET_BITS +: INDEX_BITS];
   assign req_word  = dmemaddr[2];

   // both ways compared in parallel
   assign hit_left  = valid[0][req_index] && (tags[0][req_index] == req_tag);
   assign hit_right = valid[1][req_index] && (tags[1][req_index] == req_tag);
   assign hit       = hit_left | hit_right;
   assign hit_way   = way_t'(hit_right);

   assign victim       = lru[req_index];
   assign victim_dirty = valid[victim][req_index] && dirty[victim][req_index];
   assign frame_dirty  = valid[frame_way][frame_index] && dirty[frame_way][frame_index];

   // hits are only served in IDLE; a read wins if both strobes are up
   assign dhit   = (state == IDLE) && (dmemREN || dmemWEN) && hit;
   assign rd_hit = dhit && dmemREN;
   assign wr_hit = dhit && !dmemREN;

   assign dmemload = req_word ? data1[hit_way][req_index] : data0[hit_way][req_index];

   // a memory word moves on any edge with dwait low
   assign xfer   = !dwait;
   // second word of the block in the *2 states
   assign second = (state == WB2) || (state == READ2) || (state == FLUSH2);

   always_comb
   begin
      daddr  = '0;
      dstore = '0;
      unique case (state)
         WB1, WB2:
         begin
            // victim block of the requested set
            daddr  = {tags[victim][req_index], req_index, second, 2'b00};
            dstore = second ? data1[victim][req_index] : data0[victim][req_index];
         end
         READ1, READ2:
         begin
            daddr = {req_tag, req_index, second, 2'b00};
         end
         FLUSH1, FLUSH2:
         begin
            // frame picked by the flush counter
            daddr  = {tags[frame_way][frame_index], frame_index, second, 2'b00};
            dstore = second ? data1[frame_way][frame_index] : data0[frame_way][frame_index];
         end
         default:
         begin
            daddr  = '0;
            dstore = '0;
         end
      endcase
   end

   // tag and data arrays
   always_ff @(posedge CLK)
   begin
      if (wr_hit)
      begin
         if (req_word)
         begin
            data1[hit_way][req_index] <= dmemstore;
         end
         else
         begin
            data0[hit_way][req_index] <= dmemstore;
         end
      end
      // fill words land in the victim frame
      if (state == READ1 && xfer)
      begin
         data0[victim][req_index] <= dload;
      end
      if (state == READ2 && xfer)
      begin
         data1[victim][req_index] <= dload;
         tags[victim][req_index]  <= req_tag;
      end
   end

   // valid, dirty and LRU bits
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < SETS; s++)
         begin
            valid[0][s] <= 1'b0;
            valid[1][s] <= 1'b0;
            dirty[0][s] <= 1'b0;
            dirty[1][s] <= 1'b0;
            lru[s]      <= '0;
         end
      end
      else
      begin
         // the other way becomes least recently used
         if (rd_hit || wr_hit)
         begin
            lru[req_index] <= ~hit_way;
         end
         if (wr_hit)
         begin
            dirty[hit_way][req_index] <= 1'b1;
         end
         // victim is clean once its second word is out
         if (state == WB2 && xfer)
         begin
            dirty[victim][req_index] <= 1'b0;
         end
         // fill done, install as a clean valid block
         if (state == READ2 && xfer)
         begin
            valid[victim][req_index] <= 1'b1;
            dirty[victim][req_index] <= 1'b0;
            lru[req_index]           <= ~victim;
         end
         if (state == FLUSH2 && xfer)
         begin
            dirty[frame_way][frame_index] <= 1'b0;
         end
      end
   end

endmodule

// File: dcache/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
   import dcache_pkg::*;
#(
   parameter int INDEX_BITS = DEFAULT_INDEX_BITS
)
(
   input  logic  CLK,
   input  logic  nRST,

   // processor side
   input  logic  halt,
   input  logic  dmemREN,
   input  logic  dmemWEN,
   input  addr_t dmemaddr,
   input  word_t dmemstore,
   output logic  dhit,
   output word_t dmemload,
   output logic  flushed,

   // memory side
   output logic  dREN,
   output logic  dWEN,
   output addr_t daddr,
   output word_t dstore,
   input  word_t dload,
   input  logic  dwait
);

   cache_state_t state;
   logic hit;
   logic victim_dirty;
   logic frame_dirty;
   logic count_en;
   logic count_clr;
   logic walk_done;
   way_t frame_way;
   logic [INDEX_BITS-1:0] frame_index;

   // sequencing for misses and the flush walk
   cache_ctrl u_ctrl (
      .CLK          (CLK),
      .nRST         (nRST),
      .halt         (halt),
      .dmemREN      (dmemREN),
      .dmemWEN      (dmemWEN),
      .dwait        (dwait),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .frame_dirty  (frame_dirty),
      .walk_done    (walk_done),
      .state        (state),
      .count_en     (count_en),
      .count_clr    (count_clr),
      .dREN         (dREN),
      .dWEN         (dWEN),
      .flushed      (flushed)
   );

   // frame pointer used only while flushing
   flush_counter #(
      .INDEX_BITS (INDEX_BITS)
   ) u_counter (
      .CLK         (CLK),
      .nRST        (nRST),
      .count_en    (count_en),
      .count_clr   (count_clr),
      .frame_way   (frame_way),
      .frame_index (frame_index),
      .walk_done   (walk_done)
   );

   // arrays plus hit compare and memory address/data muxing
   block_store #(
      .INDEX_BITS (INDEX_BITS)
   ) u_store (
      .CLK          (CLK),
      .nRST         (nRST),
      .state        (state),
      .dmemREN      (dmemREN),
      .dmemWEN      (dmemWEN),
      .dwait        (dwait),
      .dmemaddr     (dmemaddr),
      .dmemstore    (dmemstore),
      .dload        (dload),
      .frame_way    (frame_way),
      .frame_index  (frame_index),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .frame_dirty  (frame_dirty),
      .dhit         (dhit),
      .dmemload     (dmemload),
      .dstore       (dstore),
      .daddr        (daddr)
   );

endmodule

// File: dv/ram_model.sv
`timescale 1ns/1ps

module ram_model
   import dcache_pkg::*;
#(
   parameter int WORDS = 512
)
(
   input  logic        CLK,
   input  logic        dREN,
   input  logic        dWEN,
   input  addr_t       daddr,
   input  word_t       dstore,
   output word_t       dload,
   output logic        dwait,
   output int unsigned wb_count,
   output int unsigned rd_count,
   output addr_t       last_wb_addr
);

   localparam int AW = $clog2(WORDS);

   word_t mem [WORDS];
   logic  wr_now;
   logic  rd_now;
   addr_t wr_addr;
   word_t wr_data;

   // start-up contents, a different word for every address
   function automatic word_t fill_word(input addr_t a);
      return a ^ 32'h5a5a_c3c3;
   endfunction

   // reads are combinational on the word address
   assign dload = mem[daddr[AW+1:2]];

   // bus sampled mid-cycle where it is stable
   // a transfer completes at the next rising edge when dwait is low
   initial
   begin
      wr_now  = 1'b0;
      rd_now  = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      forever
      begin
         @(negedge CLK);
         wr_now  = dWEN && !dwait;
         rd_now  = dREN && !dwait;
         wr_addr = daddr;
         wr_data = dstore;
      end
   end

   initial
   begin
      for (int i = 0; i < WORDS; i++)
      begin
         mem[i] = fill_word(addr_t'(i << 2));
      end
      dwait        = 1'b0;
      wb_count     = 0;
      rd_count     = 0;
      last_wb_addr = '0;
      forever
      begin
         @(posedge CLK);
         if (wr_now)
         begin
            mem[wr_addr[AW+1:2]] = wr_data;
            wb_count             = wb_count + 1;
            last_wb_addr         = wr_addr;
         end
         // completed read words
         if (rd_now)
         begin
            rd_count = rd_count + 1;
         end
         // new stall decision a little after the edge
         #1;
         dwait = ($urandom % 3) == 0;
      end
   end

endmodule

// File: dv/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache
   import dcache_pkg::*;
();

   localparam int INDEX_BITS     = DEFAULT_INDEX_BITS;
   localparam int RAM_WORDS      = 512;
   localparam int ACCESS_TIMEOUT = 200;
   localparam int FLUSH_TIMEOUT  = 4000;
   localparam int RANDOM_OPS     = 400;

   logic        CLK = 1'b0;
   logic        nRST;
   logic        halt;
   logic        dmemREN;
   logic        dmemWEN;
   addr_t       dmemaddr;
   word_t       dmemstore;
   logic        dhit;
   word_t       dmemload;
   logic        flushed;
   logic        dREN;
   logic        dWEN;
   addr_t       daddr;
   word_t       dstore;
   word_t       dload;
   logic        dwait;
   int unsigned wb_count;
   int unsigned rd_count;
   addr_t       last_wb_addr;

   // latest value of every memory word as the processor sees it
   word_t ref_mem [RAM_WORDS];

   always #50 CLK = ~CLK;

   dcache_top #(.INDEX_BITS(INDEX_BITS)) DUT (.*);

   ram_model #(.WORDS(RAM_WORDS)) u_ram (.*);

   // same start-up pattern as the memory
   function automatic word_t initial_word(input addr_t a);
      return a ^ 32'h5a5a_c3c3;
   endfunction

   function automatic int word_index(input addr_t a);
      return int'(a >> 2) % RAM_WORDS;
   endfunction

   // tag, set and word number to byte address
   function automatic addr_t make_addr(input int tag, input int set, input int word);
      return addr_t'((tag << (INDEX_BITS + WORD_OFFSET_BITS)) | (set << 3) | (word << 2));
   endfunction

   task automatic fail_now(input string what);
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp)
         fail_now($sformatf("error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp)
         fail_now($sformatf("error %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_now($sformatf("error %s: expected %b, actual %b", name, exp, act));
   endtask

   // one processor access, entered just after a rising edge
   // waited counts the cycles before dhit, 0 means a hit in the request cycle
   task automatic access(input string name, input logic wr, input addr_t a,
                         input word_t d, output int waited);
      logic done;
      done      = 1'b0;
      waited    = 0;
      dmemREN   = !wr;
      dmemWEN   = wr;
      dmemaddr  = a;
      dmemstore = d;
      while (!done)
      begin
         @(negedge CLK);
         if (dhit)
            done = 1'b1;
         else
         begin
            waited++;
            if (waited > ACCESS_TIMEOUT)
               fail_now($sformatf("timeout: no dhit for access to address %h", a));
         end
      end
      if (wr)
         ref_mem[word_index(a)] = d;
      else
         check_word(name, ref_mem[word_index(a)], dmemload);
      @(posedge CLK);
      #1;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
   endtask

   // two sets and eight tags, so the two ways thrash
   task automatic random_traffic(input int ops);
      addr_t a;
      logic  wr;
      word_t d;
      int    waited;
      for (int i = 0; i < ops; i++)
      begin
         a  = make_addr(int'($urandom % 8), int'($urandom % 2), int'($urandom % 2));
         wr = 1'($urandom);
         d  = $urandom;
         access("random_read", wr, a, d, waited);
      end
   endtask

   initial
   begin
      int          waited;
      int unsigned base_count;
      void'($urandom(67463));
      nRST      = 1'b0;
      halt      = 1'b0;
      dmemREN   = 1'b0;
      dmemWEN   = 1'b0;
      dmemaddr  = '0;
      dmemstore = '0;
      for (int i = 0; i < RAM_WORDS; i++)
         ref_mem[i] = initial_word(addr_t'(i << 2));
      repeat (10) @(posedge CLK);
      #1;
      nRST = 1'b1;
      // quiet cache after reset
      @(negedge CLK);
      check_bit("reset_dhit", 1'b0, dhit);
      check_bit("reset_flushed", 1'b0, flushed);
      check_bit("reset_dREN", 1'b0, dREN);
      check_bit("reset_dWEN", 1'b0, dWEN);
      @(posedge CLK);
      #1;

      // read data against the model under heavy eviction
      random_traffic(RANDOM_OPS);

      // fill then hit, on a set the traffic never touches
      // the frame is invalid, so the miss is two memory reads and no write-back
      base_count = rd_count;
      access("fill_read", 1'b0, make_addr(8, 2, 1), '0, waited);
      check_bit("fill_miss", 1'b0, logic'(waited == 0));
      check_word("fill_reads", word_t'(base_count + 2), word_t'(rd_count));
      access("fill_read", 1'b0, make_addr(8, 2, 1), '0, waited);
      check_bit("fill_then_hit", 1'b1, logic'(waited == 0));

      // LRU, A and B fill set 3, A is touched again, C must push out B
      access("lru_read", 1'b0, make_addr(9, 3, 0), '0, waited);
      access("lru_read", 1'b0, make_addr(10, 3, 0), '0, waited);
      access("lru_read", 1'b0, make_addr(9, 3, 0), '0, waited);
      check_bit("lru_a_touch", 1'b1, logic'(waited == 0));
      access("lru_read", 1'b0, make_addr(11, 3, 0), '0, waited);
      check_bit("lru_c_miss", 1'b0, logic'(waited == 0));
      access("lru_read", 1'b0, make_addr(9, 3, 0), '0, waited);
      check_bit("lru_a_kept", 1'b1, logic'(waited == 0));
      access("lru_read", 1'b0, make_addr(10, 3, 0), '0, waited);
      check_bit("lru_b_evicted", 1'b0, logic'(waited == 0));

      // dirty write-back, X is dirty and least recent when Z comes in
      access("wb_write", 1'b1, make_addr(12, 4, 0), $urandom, waited);
      access("wb_write", 1'b1, make_addr(12, 4, 1), $urandom, waited);
      access("wb_write", 1'b1, make_addr(13, 4, 1), $urandom, waited);
      base_count = wb_count;
      access("wb_read", 1'b0, make_addr(14, 4, 0), '0, waited);
      check_word("wb_count", word_t'(base_count + 2), word_t'(wb_count));
      check_addr("wb_addr", make_addr(12, 4, 1), last_wb_addr);
      check_word("wb_ram_word0", ref_mem[word_index(make_addr(12, 4, 0))],
                 u_ram.mem[word_index(make_addr(12, 4, 0))]);
      check_word("wb_ram_word1", ref_mem[word_index(make_addr(12, 4, 1))],
                 u_ram.mem[word_index(make_addr(12, 4, 1))]);

      // flush on halt after more traffic
      random_traffic(RANDOM_OPS / 2);
      halt   = 1'b1;
      waited = 0;
      while (!flushed)
      begin
         @(negedge CLK);
         waited++;
         if (waited > FLUSH_TIMEOUT)
            fail_now("timeout: flushed never rose after halt");
      end
      for (int i = 0; i < 8; i++)
      begin
         @(negedge CLK);
         check_bit("flushed_held", 1'b1, flushed);
      end
      for (int i = 0; i < RAM_WORDS; i++)
         check_word($sformatf("flush_ram_%0d", i), ref_mem[i], u_ram.mem[i]);

      $display("all tests passed");
      $finish;
   end

endmodule

// File: sim.f
common/dcache_pkg.sv
logic/flush_counter.sv
dcache/cache_ctrl.sv
dcache/block_store.sv
dcache/dcache_top.sv
dv/ram_model.sv
dv/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_dcache -f sim.f -o tb_dcache &&
./obj_dir/tb_dcache | tee /dev/stderr | grep -q "all tests passed" &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }
